// File: build.f
rtl/lcdPkg.sv
rtl/lcdScript.sv
rtl/lcdSequencer.sv
rtl/lcdBusWriter.sv
rtl/lcdController.sv
dv/lcdTb.sv

// File: Makefile
# Verilator build and run for the TFT command sequencer

VERILATOR ?= verilator
TOP ?= lcdTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
PASS_TEXT ?= Simulation finished: PASS

SRCS := $(wildcard rtl/*.sv) $(wildcard dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, whatever the simulator exit status is
run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/lcdTb.sv
`timescale 1ns/1ps

module lcdTb;

  // one expected panel byte and the least number of cycles since the previous one
  typedef struct packed {
    logic [31:0] minGap;
    logic isData;
    logic [7:0] value;
  } expT;

  typedef expT expQT[$];

  // all script waits summed, plus room for the write cycles
  localparam logic [31:0] SCRIPT_CYCLES = 32'd2 * lcdPkg::RESET_WAIT +
                                          32'd4 * lcdPkg::WAKE_WAIT +
                                          lcdPkg::SLEEP_WAIT + 32'd1000;
  localparam logic [31:0] TIMEOUT_CYCLES = SCRIPT_CYCLES + 32'd10_000;

  logic clk;
  logic rst;
  logic [31:0] controlBus;
  logic [31:0] xBus;
  logic [31:0] yBus;
  logic ack;
  logic csx;
  logic dcx;
  logic wrx;
  logic [7:0] data;

  expQT expQ;
  logic [8:0] gotByteQ[$];
  logic [31:0] gotCycleQ[$];
  event gotByte;
  logic [31:0] cycleCnt = '0;
  logic [31:0] ackCount = '0;
  logic [31:0] wrxFalls = '0;
  logic [31:0] lastRise = '0;
  logic prevWrx = 1'b1;
  logic [31:0] lcgState = 32'h95f6_3f95;
  int errors = 0;
  int checks = 0;

  lcdController dut (
    .clk(clk),
    .rst(rst),
    .controlBus(controlBus),
    .xBus(xBus),
    .yBus(yBus),
    .ack(ack),
    .csx(csx),
    .dcx(dcx),
    .wrx(wrx),
    .data(data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] want,
                            input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  function automatic expT makeItem(input logic [31:0] gap, input logic isData,
                                   input logic [7:0] value);
    expT item;
    item.minGap = gap;
    item.isData = isData;
    item.value = value;
    return item;
  endfunction

  function automatic logic [15:0] colourOf(input int opBit);
    case (opBit)
      lcdPkg::OP_RED: return lcdPkg::COLOR_RED;
      lcdPkg::OP_GREEN: return lcdPkg::COLOR_GREEN;
      lcdPkg::OP_BLUE: return lcdPkg::COLOR_BLUE;
      lcdPkg::OP_WHITE: return lcdPkg::COLOR_WHITE;
      default: return lcdPkg::COLOR_BLACK;
    endcase
  endfunction

  // wait a script still runs after its last byte
  function automatic logic [31:0] tailWait(input int opBit);
    if (opBit == lcdPkg::OP_DISP_OFF)
      return lcdPkg::SLEEP_WAIT;
    if (opBit == lcdPkg::OP_DISP_ON)
      return lcdPkg::WAKE_WAIT;
    return 32'd0;
  endfunction

  function automatic expQT expectedBytes(input int opBit, input logic [31:0] x,
                                         input logic [31:0] y);
    expQT q;
    logic [15:0] colour;
    colour = colourOf(opBit);
    case (opBit)
      lcdPkg::OP_INIT: begin
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_SLEEP_IN));
        q.push_back(makeItem(lcdPkg::RESET_WAIT, 1'b0, lcdPkg::CMD_SW_RESET));
        q.push_back(makeItem(lcdPkg::RESET_WAIT, 1'b0, lcdPkg::CMD_SLEEP_OUT));
        q.push_back(makeItem(lcdPkg::WAKE_WAIT, 1'b0, lcdPkg::CMD_PIXEL_FMT));
        q.push_back(makeItem(0, 1'b1, lcdPkg::PARAM_PIXEL_FMT));
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_ORIENT));
        q.push_back(makeItem(0, 1'b1, lcdPkg::PARAM_ORIENT));
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_DISP_ON));
      end
      lcdPkg::OP_DISP_OFF: begin
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_DISP_OFF));
        q.push_back(makeItem(lcdPkg::WAKE_WAIT, 1'b0, lcdPkg::CMD_SLEEP_IN));
      end
      lcdPkg::OP_DISP_ON: begin
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_SLEEP_OUT));
        q.push_back(makeItem(lcdPkg::WAKE_WAIT, 1'b0, lcdPkg::CMD_DISP_ON));
      end
      default: begin
        // window bytes go out high byte first
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_COL_ADDR));
        for (int i = 3; i >= 0; i--)
          q.push_back(makeItem(0, 1'b1, x[i*8 +: 8]));
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_PAGE_ADDR));
        for (int i = 3; i >= 0; i--)
          q.push_back(makeItem(0, 1'b1, y[i*8 +: 8]));
        q.push_back(makeItem(0, 1'b0, lcdPkg::CMD_MEM_WRITE));
        q.push_back(makeItem(0, 1'b1, colour[15:8]));
        q.push_back(makeItem(0, 1'b1, colour[7:0]));
      end
    endcase
    return q;
  endfunction

  // counters change on the falling edge and are read on the rising edge
  always @(negedge clk) begin
    cycleCnt = cycleCnt + 1;
    if (ack === 1'b1)
      ackCount = ackCount + 1;
    if (prevWrx === 1'b1 && wrx === 1'b0)
      wrxFalls = wrxFalls + 1;
    prevWrx = wrx;
    if (cycleCnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // panel latches on the rising wrx edge
  always @(posedge wrx) begin
    if (rst === 1'b0 && csx === 1'b0) begin
      gotByteQ.push_back({dcx, data});
      gotCycleQ.push_back(cycleCnt);
      ->gotByte;
    end
  end

  initial begin : compareBytes
    logic [8:0] rec;
    logic [31:0] cyc;
    expT want;
    int byteNo;
    byteNo = 0;
    forever begin
      @(gotByte);
      while (gotByteQ.size() > 0) begin
        rec = gotByteQ.pop_front();
        cyc = gotCycleQ.pop_front();
        byteNo++;
        if (expQ.size() == 0) begin
          errors++;
          $display("extra byte %02h appeared on the panel bus at %0t ns", rec[7:0], $time);
        end else begin
          want = expQ.pop_front();
          checkValue(32'(rec[8]), 32'(want.isData), $sformatf("dcx of byte %0d", byteNo));
          checkValue(32'(rec[7:0]), 32'(want.value), $sformatf("value of byte %0d", byteNo));
          if (want.minGap != 0)
            checkValue(32'(cyc - lastRise >= want.minGap), 32'd1,
                       $sformatf("wait of %0d cycles before byte %0d", want.minGap, byteNo));
        end
        lastRise = cyc;
      end
    end
  end

  task automatic runScript(input int opBit, input logic [31:0] x, input logic [31:0] y,
                           input bit hold);
    logic [31:0] limit;
    logic [31:0] startCycle;
    logic [31:0] startAck;
    expQT want;
    want = expectedBytes(opBit, x, y);
    limit = tailWait(opBit) + 32'd100;
    foreach (want[i])
      limit = limit + want[i].minGap + 32'd8;
    expQ = want;
    startAck = ackCount;
    @(posedge clk);
    #1;
    xBus = x;
    yBus = y;
    controlBus = 32'd1 << opBit;
    startCycle = cycleCnt;
    while (ackCount == startAck && cycleCnt - startCycle < limit)
      @(posedge clk);
    if (ackCount == startAck) begin
      errors++;
      $display("no ack for opcode bit %0d within %0d cycles", opBit, limit);
    end else if (tailWait(opBit) != 0) begin
      checkValue(32'(cycleCnt - lastRise >= tailWait(opBit)), 32'd1, "wait after the last byte");
    end
    if (expQ.size() != 0) begin
      errors++;
      $display("%0d bytes of opcode bit %0d never reached the panel", expQ.size(), opBit);
    end
    @(negedge clk);
    checkValue(32'(csx), 32'd1, "csx after the end step");
    if (!hold) begin
      @(posedge clk);
      #1;
      controlBus = '0;
    end
    repeat (3) @(posedge clk);
    checkValue(ackCount - startAck, 32'd1, "ack pulses of one run");
  endtask

  // a bad opcode must leave the panel bus quiet
  task automatic checkIgnored(input logic [31:0] value);
    logic [31:0] startFalls;
    logic [31:0] startAck;
    @(posedge clk);
    #1;
    startFalls = wrxFalls;
    startAck = ackCount;
    controlBus = value;
    repeat (100) @(posedge clk);
    checkValue(wrxFalls - startFalls, 0, $sformatf("wrx strobes for controlBus %08h", value));
    checkValue(ackCount - startAck, 0, $sformatf("acks for controlBus %08h", value));
    @(negedge clk);
    checkValue(32'(csx), 32'd1, "csx for an invalid opcode");
    @(posedge clk);
    #1;
    controlBus = '0;
    repeat (2) @(posedge clk);
  endtask

  initial begin : stimulus
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] startFalls;
    logic [31:0] startAck;
    rst = 1'b1;
    controlBus = '0;
    xBus = '0;
    yBus = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    checkValue(32'(csx), 32'd1, "csx after reset");
    checkValue(32'(wrx), 32'd1, "wrx after reset");
    checkValue(32'(dcx), 32'd1, "dcx after reset");
    checkValue(32'(data), 32'd0, "data after reset");
    checkValue(32'(ack), 32'd0, "ack after reset");

    runScript(lcdPkg::OP_INIT, 0, 0, 1'b0);
    runScript(lcdPkg::OP_DISP_OFF, 0, 0, 1'b0);
    runScript(lcdPkg::OP_DISP_ON, 0, 0, 1'b0);

    // colour opcodes sit in bits 4 down to 0
    for (int bitNo = lcdPkg::OP_RED; bitNo >= lcdPkg::OP_WHITE; bitNo--) begin
      x = nextRand();
      y = nextRand();
      runScript(bitNo, x, y, 1'b0);
    end

    // held opcode after ack, no restart until controlBus clears
    x = nextRand();
    y = nextRand();
    runScript(lcdPkg::OP_GREEN, x, y, 1'b1);
    startFalls = wrxFalls;
    startAck = ackCount;
    repeat (50) @(posedge clk);
    checkValue(wrxFalls - startFalls, 0, "wrx strobes while controlBus is held");
    checkValue(ackCount - startAck, 0, "acks while controlBus is held");
    #1;
    controlBus = '0;
    repeat (2) @(posedge clk);
    x = nextRand();
    y = nextRand();
    runScript(lcdPkg::OP_BLUE, x, y, 1'b0);

    checkIgnored(32'h0000_0018);
    checkIgnored(32'h0000_1000);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: rtl/lcdController.sv
`timescale 1ns/1ps

module lcdController (
  input logic clk,
  input logic rst,
  input logic [lcdPkg::CMD_W-1:0] controlBus,
  input logic [lcdPkg::CMD_W-1:0] xBus,
  input logic [lcdPkg::CMD_W-1:0] yBus,
  output logic ack,
  output logic csx,
  output logic dcx,
  output logic wrx,
  output logic [lcdPkg::BYTE_W-1:0] data
);

  lcdPkg::opSelT opSel;
  logic [lcdPkg::STEP_IDX_W-1:0] stepIdx;
  lcdPkg::stepT step;
  logic wrReq;
  logic [lcdPkg::BYTE_W-1:0] wrByte;
  logic wrIsData;
  logic wrDone;

  // script walker, owns csx and ack
  lcdSequencer uSequencer (
    .clk(clk),
    .rst(rst),
    .controlBus(controlBus),
    .xBus(xBus),
    .yBus(yBus),
    .step(step),
    .wrDone(wrDone),
    .opSel(opSel),
    .stepIdx(stepIdx),
    .wrReq(wrReq),
    .wrByte(wrByte),
    .wrIsData(wrIsData),
    .csx(csx),
    .ack(ack)
  );

  lcdScript uScript (
    .opSel(opSel),
    .stepIdx(stepIdx),
    .step(step)
  );

  // 8080 write strobe generation
  lcdBusWriter uBusWriter (
    .clk(clk),
    .rst(rst),
    .wrReq(wrReq),
    .wrByte(wrByte),
    .wrIsData(wrIsData),
    .wrDone(wrDone),
    .dcx(dcx),
    .wrx(wrx),
    .data(data)
  );

endmodule

// File: rtl/lcdBusWriter.sv
`timescale 1ns/1ps

module lcdBusWriter (
  input logic clk,
  input logic rst,
  input logic wrReq,
  input logic [lcdPkg::BYTE_W-1:0] wrByte,
  input logic wrIsData,
  output logic wrDone,
  output logic dcx,
  output logic wrx,
  output logic [lcdPkg::BYTE_W-1:0] data
);

  logic busy;
  logic [lcdPkg::WR_PHASE_W-1:0] phase;

  // last high cycle of the strobe
  assign wrDone = busy && (phase == lcdPkg::WR_LAST);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      phase <= '0;
      wrx <= 1'b1;
      dcx <= 1'b1;
      data <= '0;
    end else begin
      if (wrReq) begin
        // dcx low marks a command byte
        busy <= 1'b1;
        phase <= '0;
        wrx <= 1'b0;
        dcx <= wrIsData;
        data <= wrByte;
      end else if (busy) begin
        phase <= phase + 1'b1;
        // panel latches on this rising edge
        if (phase == lcdPkg::WR_LOW_LAST)
          wrx <= 1'b1;
        if (phase == lcdPkg::WR_LAST)
          busy <= 1'b0;
      end
    end
  end

  // dcx and data hold their value until the next request

endmodule

// File: rtl/lcdSequencer.sv
`timescale 1ns/1ps

module lcdSequencer (
  input logic clk,
  input logic rst,
  input logic [lcdPkg::CMD_W-1:0] controlBus,
  input logic [lcdPkg::CMD_W-1:0] xBus,
  input logic [lcdPkg::CMD_W-1:0] yBus,
  input lcdPkg::stepT step,
  input logic wrDone,
  output lcdPkg::opSelT opSel,
  output logic [lcdPkg::STEP_IDX_W-1:0] stepIdx,
  output logic wrReq,
  output logic [lcdPkg::BYTE_W-1:0] wrByte,
  output logic wrIsData,
  output logic csx,
  output logic ack
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ISSUE,
    S_WRITE,
    S_WAIT,
    S_ACK,
    S_REARM
  } stateT;

  stateT state;
  lcdPkg::opSelT decodedSel;
  logic [31:0] waitCnt;
  logic [31:0] waitLen;
  logic [lcdPkg::CMD_W-1:0] coordBus;
  logic isCoord;

  // anything not exactly one known opcode bit decodes to OP_NONE
  always_comb begin
    decodedSel = lcdPkg::OP_NONE;
    if ($onehot(controlBus)) begin
      if (controlBus[lcdPkg::OP_INIT]) decodedSel = lcdPkg::SEL_INIT;
      else if (controlBus[lcdPkg::OP_DISP_ON]) decodedSel = lcdPkg::SEL_DISP_ON;
      else if (controlBus[lcdPkg::OP_DISP_OFF]) decodedSel = lcdPkg::SEL_DISP_OFF;
      else if (controlBus[lcdPkg::OP_RED]) decodedSel = lcdPkg::SEL_RED;
      else if (controlBus[lcdPkg::OP_GREEN]) decodedSel = lcdPkg::SEL_GREEN;
      else if (controlBus[lcdPkg::OP_BLUE]) decodedSel = lcdPkg::SEL_BLUE;
      else if (controlBus[lcdPkg::OP_BLACK]) decodedSel = lcdPkg::SEL_BLACK;
      else if (controlBus[lcdPkg::OP_WHITE]) decodedSel = lcdPkg::SEL_WHITE;
    end
  end

  always_comb begin
    case (step.waitSel)
      lcdPkg::WAIT_RESET: waitLen = lcdPkg::RESET_WAIT;
      lcdPkg::WAIT_SLEEP: waitLen = lcdPkg::SLEEP_WAIT;
      default: waitLen = lcdPkg::WAKE_WAIT;
    endcase
  end

  // coordinate slots pull a byte from the window buses, high byte first
  assign isCoord = (step.kind == lcdPkg::STEP_PARAM) && (step.waitSel == lcdPkg::WAIT_COORD);
  assign coordBus = step.value[2] ? yBus : xBus;

  always_comb begin
    if (isCoord)
      wrByte = coordBus[{step.value[1:0], 3'b000} +: lcdPkg::BYTE_W];
    else
      wrByte = step.value;
  end

  assign wrIsData = (step.kind == lcdPkg::STEP_PARAM);
  assign wrReq = (state == S_ISSUE) &&
                 ((step.kind == lcdPkg::STEP_CMD) || (step.kind == lcdPkg::STEP_PARAM));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
      opSel <= lcdPkg::OP_NONE;
      stepIdx <= '0;
      waitCnt <= '0;
      csx <= 1'b1;
      ack <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (state)
        S_IDLE: begin
          if (decodedSel != lcdPkg::OP_NONE) begin
            opSel <= decodedSel;
            stepIdx <= '0;
            csx <= 1'b0;
            state <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          case (step.kind)
            lcdPkg::STEP_CMD, lcdPkg::STEP_PARAM: state <= S_WRITE;
            lcdPkg::STEP_WAIT: begin
              // the issue cycle counts as the first wait cycle
              waitCnt <= waitLen - 32'd1;
              state <= S_WAIT;
            end
            default: begin
              csx <= 1'b1;
              state <= S_ACK;
            end
          endcase
        end
        S_WRITE: begin
          if (wrDone) begin
            stepIdx <= stepIdx + 1'b1;
            state <= S_ISSUE;
          end
        end
        S_WAIT: begin
          if (waitCnt == 32'd1) begin
            stepIdx <= stepIdx + 1'b1;
            state <= S_ISSUE;
          end else begin
            waitCnt <= waitCnt - 32'd1;
          end
        end
        S_ACK: begin
          ack <= 1'b1;
          opSel <= lcdPkg::OP_NONE;
          state <= S_REARM;
        end
        // host must release controlBus before the next run
        default: begin
          if (controlBus == '0)
            state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// File: rtl/lcdScript.sv
`timescale 1ns/1ps

module lcdScript (
  input lcdPkg::opSelT opSel,
  input logic [lcdPkg::STEP_IDX_W-1:0] stepIdx,
  output lcdPkg::stepT step
);

  logic [15:0] color;

  function automatic lcdPkg::stepT cmdStep(input logic [lcdPkg::BYTE_W-1:0] value);
    return '{kind: lcdPkg::STEP_CMD, value: value, waitSel: lcdPkg::WAIT_RESET};
  endfunction

  function automatic lcdPkg::stepT paramStep(input logic [lcdPkg::BYTE_W-1:0] value);
    return '{kind: lcdPkg::STEP_PARAM, value: value, waitSel: lcdPkg::WAIT_RESET};
  endfunction

  function automatic lcdPkg::stepT waitStep(input lcdPkg::waitSelT sel);
    return '{kind: lcdPkg::STEP_WAIT, value: '0, waitSel: sel};
  endfunction

  // value bit 2 picks yBus over xBus, bits 1:0 give the byte index
  function automatic lcdPkg::stepT slotStep(input logic isY, input logic [1:0] idx);
    return '{kind: lcdPkg::STEP_PARAM,
             value: {{(lcdPkg::BYTE_W - 3){1'b0}}, isY, idx},
             waitSel: lcdPkg::WAIT_COORD};
  endfunction

  function automatic lcdPkg::stepT endStep();
    return '{kind: lcdPkg::STEP_END, value: '0, waitSel: lcdPkg::WAIT_RESET};
  endfunction

  // colour bytes of the pixel scripts
  always_comb begin
    case (opSel)
      lcdPkg::SEL_RED: color = lcdPkg::COLOR_RED;
      lcdPkg::SEL_GREEN: color = lcdPkg::COLOR_GREEN;
      lcdPkg::SEL_BLUE: color = lcdPkg::COLOR_BLUE;
      lcdPkg::SEL_WHITE: color = lcdPkg::COLOR_WHITE;
      default: color = lcdPkg::COLOR_BLACK;
    endcase
  end

  always_comb begin
    step = endStep();
    case (opSel)
      lcdPkg::SEL_INIT: begin
        case (stepIdx)
          5'd0: step = cmdStep(lcdPkg::CMD_SLEEP_IN);
          5'd1: step = waitStep(lcdPkg::WAIT_RESET);
          5'd2: step = cmdStep(lcdPkg::CMD_SW_RESET);
          5'd3: step = waitStep(lcdPkg::WAIT_RESET);
          5'd4: step = cmdStep(lcdPkg::CMD_SLEEP_OUT);
          5'd5: step = waitStep(lcdPkg::WAIT_WAKE);
          5'd6: step = cmdStep(lcdPkg::CMD_PIXEL_FMT);
          5'd7: step = paramStep(lcdPkg::PARAM_PIXEL_FMT);
          5'd8: step = cmdStep(lcdPkg::CMD_ORIENT);
          5'd9: step = paramStep(lcdPkg::PARAM_ORIENT);
          5'd10: step = cmdStep(lcdPkg::CMD_DISP_ON);
          default: step = endStep();
        endcase
      end
      lcdPkg::SEL_DISP_OFF: begin
        case (stepIdx)
          5'd0: step = cmdStep(lcdPkg::CMD_DISP_OFF);
          5'd1: step = waitStep(lcdPkg::WAIT_WAKE);
          5'd2: step = cmdStep(lcdPkg::CMD_SLEEP_IN);
          5'd3: step = waitStep(lcdPkg::WAIT_SLEEP);
          default: step = endStep();
        endcase
      end
      lcdPkg::SEL_DISP_ON: begin
        case (stepIdx)
          5'd0: step = cmdStep(lcdPkg::CMD_SLEEP_OUT);
          5'd1: step = waitStep(lcdPkg::WAIT_WAKE);
          5'd2: step = cmdStep(lcdPkg::CMD_DISP_ON);
          5'd3: step = waitStep(lcdPkg::WAIT_WAKE);
          default: step = endStep();
        endcase
      end
      lcdPkg::SEL_RED, lcdPkg::SEL_GREEN, lcdPkg::SEL_BLUE,
      lcdPkg::SEL_BLACK, lcdPkg::SEL_WHITE: begin
        // shared window prologue, then the two colour bytes
        case (stepIdx)
          5'd0: step = cmdStep(lcdPkg::CMD_COL_ADDR);
          5'd1: step = slotStep(1'b0, 2'd3);
          5'd2: step = slotStep(1'b0, 2'd2);
          5'd3: step = slotStep(1'b0, 2'd1);
          5'd4: step = slotStep(1'b0, 2'd0);
          5'd5: step = cmdStep(lcdPkg::CMD_PAGE_ADDR);
          5'd6: step = slotStep(1'b1, 2'd3);
          5'd7: step = slotStep(1'b1, 2'd2);
          5'd8: step = slotStep(1'b1, 2'd1);
          5'd9: step = slotStep(1'b1, 2'd0);
          5'd10: step = cmdStep(lcdPkg::CMD_MEM_WRITE);
          5'd11: step = paramStep(color[15:8]);
          5'd12: step = paramStep(color[7:0]);
          default: step = endStep();
        endcase
      end
      default: step = endStep();
    endcase
  end

endmodule

// File: rtl/lcdPkg.sv
package lcdPkg;

  // host side bus widths
  localparam int CMD_W = 32;
  localparam int BYTE_W = 8;

  // bit positions of the one-hot opcode on controlBus
  localparam int OP_INIT = 7;
  localparam int OP_DISP_ON = 6;
  localparam int OP_DISP_OFF = 5;
  localparam int OP_RED = 4;
  localparam int OP_GREEN = 3;
  localparam int OP_BLUE = 2;
  localparam int OP_BLACK = 1;
  localparam int OP_WHITE = 0;

  // script selection held through a run
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    SEL_INIT = 4'd1,
    SEL_DISP_ON = 4'd2,
    SEL_DISP_OFF = 4'd3,
    SEL_RED = 4'd4,
    SEL_GREEN = 4'd5,
    SEL_BLUE = 4'd6,
    SEL_BLACK = 4'd7,
    SEL_WHITE = 4'd8
  } opSelT;

  // panel command set
  localparam logic [BYTE_W-1:0] CMD_SW_RESET = 8'h01;
  localparam logic [BYTE_W-1:0] CMD_SLEEP_IN = 8'h10;
  localparam logic [BYTE_W-1:0] CMD_SLEEP_OUT = 8'h11;
  localparam logic [BYTE_W-1:0] CMD_DISP_OFF = 8'h28;
  localparam logic [BYTE_W-1:0] CMD_DISP_ON = 8'h29;
  localparam logic [BYTE_W-1:0] CMD_COL_ADDR = 8'h2A;
  localparam logic [BYTE_W-1:0] CMD_PAGE_ADDR = 8'h2B;
  localparam logic [BYTE_W-1:0] CMD_MEM_WRITE = 8'h2C;
  localparam logic [BYTE_W-1:0] CMD_ORIENT = 8'h36;
  localparam logic [BYTE_W-1:0] CMD_PIXEL_FMT = 8'h3A;

  // 16-bit colour, row/column exchange orientation
  localparam logic [BYTE_W-1:0] PARAM_PIXEL_FMT = 8'h55;
  localparam logic [BYTE_W-1:0] PARAM_ORIENT = 8'hB8;

  // rgb565, sent high byte first
  localparam logic [15:0] COLOR_RED = 16'hF800;
  localparam logic [15:0] COLOR_GREEN = 16'h07E0;
  localparam logic [15:0] COLOR_BLUE = 16'h001F;
  localparam logic [15:0] COLOR_BLACK = 16'h0000;
  localparam logic [15:0] COLOR_WHITE = 16'hFFFF;

  // wait lengths in clock cycles
  localparam logic [31:0] RESET_WAIT = 32'd1_200_000;
  localparam logic [31:0] WAKE_WAIT = 32'd50_000;
  localparam logic [31:0] SLEEP_WAIT = 32'd1_200_000;

  // write strobe shape
  localparam int WR_LOW_CYCLES = 2;
  localparam int WR_HIGH_CYCLES = 2;
  localparam int WR_PHASE_W = $clog2(WR_LOW_CYCLES + WR_HIGH_CYCLES);
  localparam logic [WR_PHASE_W-1:0] WR_LOW_LAST = WR_PHASE_W'(WR_LOW_CYCLES - 1);
  localparam logic [WR_PHASE_W-1:0] WR_LAST = WR_PHASE_W'(WR_LOW_CYCLES + WR_HIGH_CYCLES - 1);

  typedef enum logic [1:0] {
    STEP_CMD = 2'd0,
    STEP_PARAM = 2'd1,
    STEP_WAIT = 2'd2,
    STEP_END = 2'd3
  } stepKindT;

  // WAIT_COORD marks a parameter step whose byte comes from xBus or yBus
  typedef enum logic [1:0] {
    WAIT_RESET = 2'd0,
    WAIT_WAKE = 2'd1,
    WAIT_SLEEP = 2'd2,
    WAIT_COORD = 2'd3
  } waitSelT;

  typedef struct packed {
    stepKindT kind;
    logic [BYTE_W-1:0] value;
    waitSelT waitSel;
  } stepT;

  localparam int STEP_IDX_W = 5;

endpackage
